// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  - files:
      - design/execPkg.sv
      - design/issueQueue.sv
      - design/alu.sv
      - design/mulUnit.sv
      - design/cdbArbiter.sv
      - design/execCluster.sv
  - target: simulation
    files:
      - testbench/execClusterTb.sv

// ==== design/alu.sv ====
// rv32 integer alu with a one-entry result slot that requests the common data bus
`timescale 1ns/10ps

module alu #(
	parameter int dataWidth = 32,
	parameter int tagWidth = 3
) (
	input logic clk,
	input logic rstN,
	input logic aluIssue, // dispatch strobe from issue queue
	input logic [execPkg::opWidth-1:0] issueOp,
	input logic [dataWidth-1:0] issueSrc1,
	input logic [dataWidth-1:0] issueSrc2,
	input logic [tagWidth-1:0] issueTag,
	input logic aluGrant, // bus arbiter took the slot
	output logic aluBusy,
	output logic aluReq,
	output logic [tagWidth-1:0] aluTag,
	output logic [dataWidth-1:0] aluData
);

	logic signed [dataWidth-1:0] srcA; // operands viewed as signed
	logic signed [dataWidth-1:0] srcB;
	logic [execPkg::shamtWidth-1:0] shamt; // only the low bits count
	logic [dataWidth-1:0] result;
	logic resultReq; // defined code, wants the bus
	logic slotFull;

	assign srcA = issueSrc1;
	assign srcB = issueSrc2;
	assign shamt = issueSrc2[execPkg::shamtWidth-1:0];

	// operation decode
	always_comb begin
		result = '0;
		resultReq = 1'b1;
		case (issueOp)
			execPkg::opAdd: result = srcA + srcB;
			execPkg::opAnd: result = srcA & srcB;
			execPkg::opOr: result = srcA | srcB;
			execPkg::opXor: result = srcA ^ srcB;
			execPkg::opSlt: result = {{(dataWidth-1){1'b0}}, srcA < srcB}; // signed
			execPkg::opSltu: result = {{(dataWidth-1){1'b0}}, issueSrc1 < issueSrc2};
			execPkg::opSll: result = issueSrc1 << shamt;
			execPkg::opSrl: result = issueSrc1 >> shamt; // zero fill
			execPkg::opSub: result = srcA - srcB;
			execPkg::opSra: result = srcA >>> shamt; // sign fill
			default: resultReq = 1'b0; // undefined, no bus request
		endcase
	end

	assign aluBusy = slotFull;
	assign aluReq = slotFull;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			slotFull <= 1'b0;
		end else begin
			if (aluGrant) slotFull <= 1'b0; // result moved to broadcast register
			if (aluIssue) slotFull <= resultReq; // undefined op leaves slot empty
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (aluIssue) begin
			aluTag <= issueTag;
			aluData <= result;
		end
	end

endmodule

// ==== design/cdbArbiter.sv ====
// round-robin common data bus arbiter with a four-phase broadcast register
`timescale 1ns/10ps

module cdbArbiter #(
	parameter int dataWidth = 32,
	parameter int tagWidth = 3
) (
	input logic clk,
	input logic rstN,
	input logic aluReq,
	input logic [tagWidth-1:0] aluTag,
	input logic [dataWidth-1:0] aluData,
	input logic mulReq,
	input logic [tagWidth-1:0] mulTag,
	input logic [dataWidth-1:0] mulData,
	input logic cdbAck, // consumer acknowledge
	output logic aluGrant,
	output logic mulGrant,
	output logic cdbReq,
	output logic [tagWidth-1:0] cdbTag,
	output logic [dataWidth-1:0] cdbData
);

	typedef enum logic [1:0] {
		cdbIdle, // broadcast register empty
		cdbRequest, // holding req, waiting for ack
		cdbRelease // req dropped, waiting for ack low
	} cdbStateType;

	cdbStateType cdbState;
	logic aluFirst; // round-robin priority, alu wins ties when set
	logic anyGrant;

	// grants only while the broadcast register is empty
	assign aluGrant = (cdbState == cdbIdle) && aluReq && (aluFirst || !mulReq);
	assign mulGrant = (cdbState == cdbIdle) && mulReq && (!aluFirst || !aluReq);
	assign anyGrant = aluGrant || mulGrant;

	assign cdbReq = (cdbState == cdbRequest);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cdbState <= cdbIdle;
			aluFirst <= 1'b1; // alu has priority after reset
		end else begin
			case (cdbState)
				cdbIdle: begin
					if (anyGrant) begin
						cdbState <= cdbRequest; // req rises next cycle
						aluFirst <= mulGrant; // loser goes first next time
					end
				end
				cdbRequest: begin
					if (cdbAck) cdbState <= cdbRelease;
				end
				cdbRelease: begin
					if (!cdbAck) cdbState <= cdbIdle; // handshake complete
				end
				default: cdbState <= cdbIdle;
			endcase
		end
	end

	// broadcast payload, stable while cdbReq is high
	always_ff @(posedge clk) begin
		if (aluGrant) begin
			cdbTag <= aluTag;
			cdbData <= aluData;
		end else if (mulGrant) begin
			cdbTag <= mulTag;
			cdbData <= mulData;
		end
	end

endmodule

// ==== design/execCluster.sv ====
// top level of the execution back end, wires issue queue, alu, multiplier and bus arbiter
`timescale 1ns/10ps

module execCluster #(
	parameter int dataWidth = 32,
	parameter int tagWidth = 3,
	parameter int queueDepth = 4 // power of two
) (
	input logic clk,
	input logic rstN,
	input logic inReq,
	input logic [execPkg::opWidth-1:0] inOp,
	input logic [dataWidth-1:0] inSrc1,
	input logic [dataWidth-1:0] inSrc2,
	input logic [tagWidth-1:0] inTag,
	input logic cdbAck,
	output logic inAck,
	output logic cdbReq,
	output logic [tagWidth-1:0] cdbTag,
	output logic [dataWidth-1:0] cdbData
);

	// shared issue bus
	logic aluIssue;
	logic mulIssue;
	logic [execPkg::opWidth-1:0] issueOp;
	logic [dataWidth-1:0] issueSrc1;
	logic [dataWidth-1:0] issueSrc2;
	logic [tagWidth-1:0] issueTag;
	// unit status and results
	logic aluBusy;
	logic aluReq;
	logic aluGrant;
	logic [tagWidth-1:0] aluTag;
	logic [dataWidth-1:0] aluData;
	logic mulReady;
	logic mulReq;
	logic mulGrant;
	logic [tagWidth-1:0] mulTag;
	logic [dataWidth-1:0] mulData;

	issueQueue #(.dataWidth(dataWidth), .tagWidth(tagWidth), .queueDepth(queueDepth)) queue (
		.clk, .rstN, .inReq, .inOp, .inSrc1, .inSrc2, .inTag, .aluBusy, .mulReady,
		.inAck, .aluIssue, .mulIssue, .issueOp, .issueSrc1, .issueSrc2, .issueTag
	);

	alu #(.dataWidth(dataWidth), .tagWidth(tagWidth)) intAlu (
		.clk, .rstN, .aluIssue, .issueOp, .issueSrc1, .issueSrc2, .issueTag, .aluGrant,
		.aluBusy, .aluReq, .aluTag, .aluData
	);

	mulUnit #(.dataWidth(dataWidth), .tagWidth(tagWidth)) mul (
		.clk, .rstN, .mulIssue, .issueSrc1, .issueSrc2, .issueTag, .mulGrant,
		.mulReady, .mulReq, .mulTag, .mulData
	);

	cdbArbiter #(.dataWidth(dataWidth), .tagWidth(tagWidth)) arbiter (
		.clk, .rstN, .aluReq, .aluTag, .aluData, .mulReq, .mulTag, .mulData, .cdbAck,
		.aluGrant, .mulGrant, .cdbReq, .cdbTag, .cdbData
	);

endmodule

// ==== design/execPkg.sv ====
// operation codes and field widths shared by every rtl file of the execution back end
package execPkg;

	// field widths
	localparam int opWidth = 4; // operation code width
	localparam int shamtWidth = 5; // low src2 bits used as shift amount

	// integer alu codes in the alu control field encoding
	localparam logic [opWidth-1:0] opAdd = 4'd0; // src1 + src2
	localparam logic [opWidth-1:0] opAnd = 4'd1; // bitwise and
	localparam logic [opWidth-1:0] opOr = 4'd2; // bitwise or
	localparam logic [opWidth-1:0] opXor = 4'd3; // bitwise xor
	localparam logic [opWidth-1:0] opSlt = 4'd4; // signed compare
	localparam logic [opWidth-1:0] opSltu = 4'd5; // unsigned compare
	localparam logic [opWidth-1:0] opSll = 4'd6; // shift left logical
	localparam logic [opWidth-1:0] opSrl = 4'd7; // shift right logical
	localparam logic [opWidth-1:0] opSub = 4'd8; // src1 - src2
	localparam logic [opWidth-1:0] opSra = 4'd9; // shift right, sign fill

	// multiplier code steers the head entry to the mul unit
	localparam logic [opWidth-1:0] opMul = 4'd10; // low word of signed product

	// codes 11..15 are undefined
	// the alu accepts them from the queue but raises no bus request
	// so the operation is retired silently without a broadcast

endpackage

// ==== design/issueQueue.sv ====
// in-order issue FIFO, takes tagged operations over a four-phase port and dispatches the head
`timescale 1ns/10ps

module issueQueue #(
	parameter int dataWidth = 32,
	parameter int tagWidth = 3,
	parameter int queueDepth = 4
) (
	input logic clk,
	input logic rstN,
	input logic inReq, // four-phase request from producer
	input logic [execPkg::opWidth-1:0] inOp,
	input logic [dataWidth-1:0] inSrc1,
	input logic [dataWidth-1:0] inSrc2,
	input logic [tagWidth-1:0] inTag,
	input logic aluBusy, // alu slot occupied
	input logic mulReady, // mul stage one can take an entry
	output logic inAck,
	output logic aluIssue, // one-cycle dispatch strobe to alu
	output logic mulIssue, // one-cycle dispatch strobe to mul
	output logic [execPkg::opWidth-1:0] issueOp,
	output logic [dataWidth-1:0] issueSrc1,
	output logic [dataWidth-1:0] issueSrc2,
	output logic [tagWidth-1:0] issueTag
);

	localparam int ptrWidth = $clog2(queueDepth); // depth is a power of two, pointers wrap
	localparam int cntWidth = $clog2(queueDepth + 1);

	typedef enum logic {hsIdle, hsAck} hsStateType;

	hsStateType hsState; // input handshake phase
	logic [ptrWidth-1:0] headPtr; // oldest entry
	logic [ptrWidth-1:0] tailPtr; // next free entry
	logic [cntWidth-1:0] count; // occupied entries
	logic [execPkg::opWidth-1:0] opMem [queueDepth];
	logic [dataWidth-1:0] src1Mem [queueDepth];
	logic [dataWidth-1:0] src2Mem [queueDepth];
	logic [tagWidth-1:0] tagMem [queueDepth];
	logic full;
	logic notEmpty;
	logic headIsMul;
	logic push;
	logic pop;

	assign full = (count == cntWidth'(queueDepth));
	assign notEmpty = (count != '0);
	assign push = (hsState == hsIdle) && inReq && !full; // accept on this edge
	assign inAck = (hsState == hsAck); // high one cycle after accept

	// head entry drives the shared issue bus
	assign issueOp = opMem[headPtr];
	assign issueSrc1 = src1Mem[headPtr];
	assign issueSrc2 = src2Mem[headPtr];
	assign issueTag = tagMem[headPtr];

	assign headIsMul = (issueOp == execPkg::opMul); // undefined codes fall to the alu
	assign aluIssue = notEmpty && !headIsMul && !aluBusy;
	assign mulIssue = notEmpty && headIsMul && mulReady;
	assign pop = aluIssue || mulIssue; // blocked head stalls everything behind it

	// entry storage, written at the tail
	always_ff @(posedge clk) begin
		if (push) begin
			opMem[tailPtr] <= inOp;
			src1Mem[tailPtr] <= inSrc1;
			src2Mem[tailPtr] <= inSrc2;
			tagMem[tailPtr] <= inTag;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hsState <= hsIdle;
			headPtr <= '0;
			tailPtr <= '0;
			count <= '0;
		end else begin
			case (hsState)
				hsIdle: if (push) hsState <= hsAck; // full queue holds ack low
				hsAck: if (!inReq) hsState <= hsIdle; // drop ack after req release
				default: hsState <= hsIdle;
			endcase
			if (push) tailPtr <= tailPtr + 1'b1;
			if (pop) headPtr <= headPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
		end
	end

endmodule

// ==== design/mulUnit.sv ====
// two-stage pipelined multiplier, low word of the signed product, held until the bus grant
`timescale 1ns/10ps

module mulUnit #(
	parameter int dataWidth = 32,
	parameter int tagWidth = 3
) (
	input logic clk,
	input logic rstN,
	input logic mulIssue, // dispatch strobe from issue queue
	input logic [dataWidth-1:0] issueSrc1,
	input logic [dataWidth-1:0] issueSrc2,
	input logic [tagWidth-1:0] issueTag,
	input logic mulGrant, // bus arbiter took stage two
	output logic mulReady,
	output logic mulReq,
	output logic [tagWidth-1:0] mulTag,
	output logic [dataWidth-1:0] mulData
);

	logic s1Valid; // stage one holds operands
	logic [dataWidth-1:0] s1Src1;
	logic [dataWidth-1:0] s1Src2;
	logic [tagWidth-1:0] s1Tag;
	logic s2Valid; // stage two holds product
	logic s2Free; // stage two can load this edge
	logic s1Free; // stage one can load this edge
	logic signed [2*dataWidth-1:0] fullProduct;

	// full signed product, only the low word is kept
	assign fullProduct = $signed(s1Src1) * $signed(s1Src2);

	assign s2Free = !s2Valid || mulGrant;
	assign s1Free = !s1Valid || s2Free; // held stage two holds stage one too
	assign mulReady = !(s1Valid && s2Valid); // two multiplies in flight max
	assign mulReq = s2Valid;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			if (s2Free) s2Valid <= s1Valid; // advance or drain
			if (s1Free) s1Valid <= mulIssue;
		end
	end

	// stage one operand capture
	always_ff @(posedge clk) begin
		if (s1Free && mulIssue) begin
			s1Src1 <= issueSrc1;
			s1Src2 <= issueSrc2;
			s1Tag <= issueTag;
		end
	end

	// stage two product register
	always_ff @(posedge clk) begin
		if (s2Free && s1Valid) begin
			mulData <= fullProduct[dataWidth-1:0];
			mulTag <= s1Tag;
		end
	end

endmodule

// ==== testbench/execClusterTb.sv ====
// testbench for the execution cluster, replays testbench/execStim.txt through both four-phase ports
`timescale 1ns/10ps

module execClusterTb;

	localparam int dataWidth = 32;
	localparam int tagWidth = 3;
	localparam int queueDepth = 4;
	localparam int numTags = 1 << tagWidth;
	localparam int clkPeriod = 100; // ns
	localparam int resetCycles = 10;
	localparam int maxLines = 64;

	logic clk;
	logic rstN;
	logic inReq;
	logic [execPkg::opWidth-1:0] inOp;
	logic [dataWidth-1:0] inSrc1;
	logic [dataWidth-1:0] inSrc2;
	logic [tagWidth-1:0] inTag;
	logic cdbAck;
	logic inAck;
	logic cdbReq;
	logic [tagWidth-1:0] cdbTag;
	logic [dataWidth-1:0] cdbData;

	// stimulus columns, one entry per data line
	logic [execPkg::opWidth-1:0] stimOp [maxLines];
	logic [dataWidth-1:0] stimSrc1 [maxLines];
	logic [dataWidth-1:0] stimSrc2 [maxLines];
	logic [dataWidth-1:0] stimExp [maxLines];
	int stimDelay [maxLines];
	int lineCount = 0;
	bit stimLoaded = 1'b0; // arms the watchdog

	// per-tag bookkeeping
	logic [dataWidth-1:0] expTable [numTags]; // expected value of the op holding the tag
	int delayTable [numTags]; // listed ack delay
	logic [numTags-1:0] pending = '0; // defined op in flight, broadcast due
	logic [tagWidth-1:0] nextTag = '0; // rotation
	logic [tagWidth-1:0] lastTag = '0;
	bit holdAck = 1'b0; // consumer withholds cdbAck
	int broadcastCount = 0;
	int definedSent = 0;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int seed = 37400;

	execCluster #(.dataWidth(dataWidth), .tagWidth(tagWidth), .queueDepth(queueDepth)) dut (
		.clk, .rstN, .inReq, .inOp, .inSrc1, .inSrc2, .inTag, .cdbAck,
		.inAck, .cdbReq, .cdbTag, .cdbData
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name, input int errorsBefore);
		testsRun++;
		if (errorCount > errorsBefore) begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	task automatic loadStim;
		int fd;
		int n;
		logic [8*256-1:0] lineBuf;
		logic [31:0] f0, f1, f2, f3, f4;
		fd = $fopen("testbench/execStim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file testbench/execStim.txt");
		end else begin
			while (!$feof(fd) && lineCount < maxLines) begin
				lineBuf = '0; // no stale text at end of file
				n = $fgets(lineBuf, fd);
				if (n > 0) begin
					n = $sscanf(lineBuf, "%h %h %h %h %h", f0, f1, f2, f3, f4);
					if (n == 5) begin // comment and blank lines give fewer fields
						stimOp[lineCount] = f0[execPkg::opWidth-1:0];
						stimSrc1[lineCount] = f1;
						stimSrc2[lineCount] = f2;
						stimExp[lineCount] = f3;
						stimDelay[lineCount] = f4;
						lineCount++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// claims the next tag and raises inReq, called on a rising edge
	task automatic startOp(input int idx);
		while (pending[nextTag]) @(posedge clk); // previous owner not broadcast yet
		lastTag = nextTag;
		nextTag = nextTag + 1'b1;
		expTable[lastTag] = stimExp[idx];
		delayTable[lastTag] = stimDelay[idx];
		if (stimOp[idx] <= execPkg::opMul) begin // undefined codes expect no broadcast
			pending[lastTag] = 1'b1;
			definedSent++;
		end
		inReq <= 1'b1;
		inOp <= stimOp[idx];
		inSrc1 <= stimSrc1[idx];
		inSrc2 <= stimSrc2[idx];
		inTag <= lastTag;
	endtask

	task automatic waitAck(input int limit, output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < limit) begin
			@(posedge clk);
			if (inAck) ok = 1'b1;
			cycles++;
		end
	endtask

	// second half of the input handshake
	task automatic finishOp;
		int cycles;
		cycles = 0;
		inReq <= 1'b0;
		@(posedge clk);
		while (inAck && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (inAck) begin
			$display("input acknowledge stayed high after the request was released");
			errorCount++;
		end
	endtask

	task automatic drain;
		while (|pending) @(posedge clk);
		repeat (20) @(posedge clk); // quiet window, a stray broadcast would show here
	endtask

	function automatic bit lineSelected(input logic [execPkg::opWidth-1:0] op, input int sel);
		case (sel)
			0: return op < execPkg::opMul; // alu codes
			1: return op == execPkg::opMul;
			default: return 1'b1; // everything, undefined too
		endcase
	endfunction

	task automatic runPass(input int sel, input string name);
		int errorsBefore;
		int i;
		bit ok;
		errorsBefore = errorCount;
		broadcastCount = 0;
		definedSent = 0;
		for (i = 0; i < lineCount; i++) begin
			if (lineSelected(stimOp[i], sel)) begin
				startOp(i);
				waitAck(200, ok);
				if (ok) begin
					finishOp();
				end else begin
					$display("no input acknowledge for stimulus line %0d", i);
					errorCount++;
					inReq <= 1'b0;
					pending[lastTag] = 1'b0;
					@(posedge clk);
				end
			end
		end
		drain();
		checkValue(broadcastCount, definedSent, {name, ": broadcast count"});
		endTest(name, errorsBefore);
	endtask

	// alu ops only, bus ack withheld until the input stalls
	task automatic fullQueueTest;
		int errorsBefore;
		int i;
		int attempts;
		int accepted;
		bit ok;
		bit refused;
		errorsBefore = errorCount;
		broadcastCount = 0;
		definedSent = 0;
		attempts = 0;
		accepted = 0;
		refused = 1'b0;
		i = 0;
		holdAck = 1'b1;
		while (!refused && attempts < queueDepth + 3 && i < lineCount) begin
			if (stimOp[i] < execPkg::opMul) begin
				startOp(i);
				attempts++;
				waitAck(20, ok); // 20 idle cycles count as a stalled input
				if (ok) begin
					accepted++;
					finishOp();
				end else begin
					refused = 1'b1;
				end
			end
			i++;
		end
		checkValue(accepted, queueDepth + 2, "operations accepted while bus ack withheld");
		checkValue(refused, 1'b1, "input still acknowledged with queue and units full");
		holdAck = 1'b0;
		if (refused) begin
			waitAck(200, ok);
			checkValue(ok, 1'b1, "blocked operation accepted after bus acks resume");
			if (ok) finishOp();
			else inReq <= 1'b0;
		end
		drain();
		checkValue(broadcastCount, definedSent, "full queue: broadcast count");
		endTest("full queue", errorsBefore);
	endtask

	// consumer side of the broadcast handshake
	initial begin : consumer
		logic [tagWidth-1:0] tag;
		logic [dataWidth-1:0] data;
		int extra;
		forever begin
			@(posedge clk);
			if (cdbReq && !holdAck) begin
				tag = cdbTag; // stable while cdbReq is high
				data = cdbData;
				checkValue(pending[tag], 1'b1, $sformatf("broadcast of tag %0d not in flight", tag));
				checkValue(data, expTable[tag], $sformatf("result for tag %0d", tag));
				pending[tag] = 1'b0;
				broadcastCount++;
				extra = $unsigned($random(seed)) % 4; // random stretch of the listed delay
				repeat (delayTable[tag] + extra) @(posedge clk);
				cdbAck <= 1'b1;
				@(posedge clk);
				while (cdbReq) @(posedge clk);
				cdbAck <= 1'b0;
			end
		end
	end

	// watchdog, 200 cycles per stimulus line on top of reset
	initial begin : watchdog
		wait (stimLoaded);
		#((resetCycles + 200 * lineCount) * clkPeriod);
		$display("timeout: the tests did not finish within %0d cycles",
			resetCycles + 200 * lineCount);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : mainSequence
		int errorsBefore;
		int i;
		rstN = 1'b0;
		inReq = 1'b0;
		inOp = '0;
		inSrc1 = '0;
		inSrc2 = '0;
		inTag = '0;
		cdbAck = 1'b0;
		loadStim();
		if (lineCount > 0) stimLoaded = 1'b1;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		if (lineCount == 0) begin
			$display("no stimulus lines read, nothing was tested");
			errorCount++;
		end else begin
			// both handshake outputs quiet while no request comes in
			errorsBefore = errorCount;
			for (i = 0; i < 8; i++) begin
				@(posedge clk);
				checkValue(inAck, 1'b0, "inAck after reset");
				checkValue(cdbReq, 1'b0, "cdbReq after reset");
			end
			endTest("reset state", errorsBefore);
			runPass(0, "alu operations");
			runPass(1, "multiply");
			runPass(2, "mixed stream with undefined codes");
			fullQueueTest();
		end
		$display("tests run %0d, tests failed %0d, check errors %0d",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/execStim.txt ====
# columns, all hex: opcode src1 src2 expected ack-delay
# expected follows rv32 rules, ignored for undefined codes 11..15
0 00000005 00000007 0000000c 0
0 ffffffff 00000001 00000000 1
8 00000003 00000005 fffffffe 2
1 f0f0f0f0 ff00ff00 f000f000 0
2 f0f0f0f0 0f0f0000 fffff0f0 3
3 aaaaaaaa ffff0000 5555aaaa 1
4 ffffffff 00000001 00000001 0
5 ffffffff 00000001 00000000 2
4 00000001 ffffffff 00000000 1
5 00000001 ffffffff 00000001 0
6 00000001 00000024 00000010 4
7 80000000 0000003f 00000001 0
9 80000000 00000004 f8000000 2
9 7ffffff0 00000024 07ffffff 1
7 f0000000 00000004 0f000000 0
0 7fffffff 00000001 80000000 3
8 00000000 00000001 ffffffff 0
a 00000006 00000007 0000002a 0
a fffffffd 00000005 fffffff1 1
a fffffffe fffffffe 00000004 0
a 80000000 00000002 00000000 5
a 12345678 00000010 23456780 0
a 00010001 00010001 00020001 2
b 00000001 00000002 00000000 0
f ffffffff ffffffff 00000000 1
c 12345678 87654321 00000000 0

// ==== verilog.f ====
design/execPkg.sv
design/issueQueue.sv
design/alu.sv
design/mulUnit.sv
design/cdbArbiter.sv
design/execCluster.sv
testbench/execClusterTb.sv
